/* include/igr_macros.svh */
// sizing constants for the ingress front end
// queue depth must stay a power of two, pointers wrap without a compare
// lane count and tc slot count are tied to 3-bit fields in igr_pkg
`ifndef IGR_MACROS_SVH
`define IGR_MACROS_SVH

// ----------------------------------------
// receive bus shape
// ----------------------------------------
// data lanes per EPL beat
`define IGR_LANES 4
// bits per lane, one beat is 64 bits
`define IGR_LANE_W 16
// logical ports on the EPL bus
`define IGR_PORTS 4

// ----------------------------------------
// queueing and pause
// ----------------------------------------
`define IGR_FIFO_DEPTH 8
`define IGR_XOFF_LVL 6
`define IGR_TC_SLOTS 8

`endif

/* design/igr_pkg.sv */
// shared types for the ingress front end
// entry layout is 89 bits with 4 lanes of 16 bits
`include "igr_macros.svh"

package igr_pkg;

  // ----------------------------------------
  // EPL side metadata
  // ----------------------------------------
  // only the fields this scaled-down block carries
  typedef struct packed {
    logic       sop;
    logic       eop;
    logic       error;
    logic [2:0] tc;
  } epl_md_t;

  // ----------------------------------------
  // per-port queue entry
  // ----------------------------------------
  // lanes holds the number of valid lanes, 0 to 4
  // ts is passed through untouched
  typedef struct packed {
    logic [`IGR_LANES*`IGR_LANE_W-1:0] data;
    logic [2:0]                        lanes;
    logic                              sop;
    logic                              eop;
    logic                              error;
    logic [2:0]                        tc;
    logic [15:0]                       ts;
  } igr_entry_t;

  // packet buffer writer FSM
  typedef enum logic [0:0] {
    PBW_IDLE,
    PBW_HOLD
  } pbw_state_e;

endpackage

/* design/igr_dpc.sv */
// EPL receive stage, no back-pressure toward EPL
// a beat with no valid lanes is never pushed
// tc sync runs free from the first reset release
`timescale 1ns/1ps
`include "igr_macros.svh"

module igr_dpc (
  input  logic                              cclk,
  input  logic                              rst,
  input  logic [1:0]                        i_rx_port_num,
  input  logic [`IGR_LANES-1:0]             i_rx_data_v,
  input  logic [`IGR_LANES*`IGR_LANE_W-1:0] i_rx_data,
  input  igr_pkg::epl_md_t                  i_rx_md,
  input  logic [15:0]                       i_rx_ts,
  output logic [`IGR_PORTS-1:0]             o_push,
  output igr_pkg::igr_entry_t               o_entry,
  output logic                              o_pfc_tc_sync
);

  logic                              q_rst;
  logic [1:0]                        s1_port;
  logic [`IGR_LANES-1:0]             s1_data_v;
  logic [`IGR_LANES*`IGR_LANE_W-1:0] s1_data;
  igr_pkg::epl_md_t                  s1_md;
  logic [15:0]                       s1_ts;
  logic [2:0]                        s1_lane_cnt;
  logic                              s1_any_v;
  logic [`IGR_PORTS-1:0]             s1_port_oh;
  logic [`IGR_TC_SLOTS-1:0]          sync_sr;
  logic                              sync_seed;

  // ----------------------------------------
  // stage 1 input flops
  // ----------------------------------------
  // partition boundary, plain flops
  always_ff @(posedge cclk) begin
    q_rst     <= rst;
    s1_port   <= i_rx_port_num;
    s1_data_v <= i_rx_data_v;
    s1_data   <= i_rx_data;
    s1_md     <= i_rx_md;
    s1_ts     <= i_rx_ts;
  end

  // count of set valid bits
  always_comb begin
    s1_lane_cnt = '0;
    for (int i = 0; i < `IGR_LANES; i++) begin
      s1_lane_cnt = s1_lane_cnt + {2'b00, s1_data_v[i]};
    end
  end

  assign s1_any_v = |s1_data_v;

  // one-hot port decode
  always_comb begin
    for (int p = 0; p < `IGR_PORTS; p++) begin
      s1_port_oh[p] = (int'(s1_port) == p);
    end
  end

  // ----------------------------------------
  // stage 2 toward the port queues
  // ----------------------------------------
  always_ff @(posedge cclk) begin
    if (rst) begin
      o_push <= '0;
    end else begin
      o_push <= s1_port_oh & {`IGR_PORTS{s1_any_v}};
    end
  end

  // one shared entry, the push strobe picks the queue
  always_ff @(posedge cclk) begin
    o_entry.data  <= s1_data;
    o_entry.lanes <= s1_lane_cnt;
    o_entry.sop   <= s1_md.sop;
    o_entry.eop   <= s1_md.eop;
    o_entry.error <= s1_md.error;
    o_entry.tc    <= s1_md.tc;
    o_entry.ts    <= s1_ts;
  end

  // ----------------------------------------
  // tc sync pulse
  // ----------------------------------------
  // seeded once on the falling edge of rst, then recirculates
  assign sync_seed = (~rst & q_rst) | sync_sr[`IGR_TC_SLOTS-1];

  always_ff @(posedge cclk) begin
    if (rst) begin
      sync_sr       <= '0;
      o_pfc_tc_sync <= 1'b0;
    end else begin
      sync_sr       <= {sync_sr[`IGR_TC_SLOTS-2:0], sync_seed};
      // output cycle is slot 0 for tc0
      o_pfc_tc_sync <= sync_sr[0];
    end
  end

endmodule

/* design/igr_port_fifo.sv */
// single port queue, depth from IGR_FIFO_DEPTH (power of two)
// a push into a full queue is dropped unless a pop frees a slot
// pop on an empty queue is ignored
`timescale 1ns/1ps
`include "igr_macros.svh"

module igr_port_fifo (
  input  logic                cclk,
  input  logic                rst,
  input  logic                i_push,
  input  igr_pkg::igr_entry_t i_entry,
  input  logic                i_pop,
  output igr_pkg::igr_entry_t o_head,
  output logic                o_empty,
  output logic [3:0]          o_level,
  output logic [7:0]          o_drop_cnt
);

  localparam int PTR_W = $clog2(`IGR_FIFO_DEPTH);

  igr_pkg::igr_entry_t mem [`IGR_FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic                full;
  logic                do_push;
  logic                do_pop;

  assign full    = (o_level == 4'(`IGR_FIFO_DEPTH));
  assign o_empty = (o_level == 4'd0);
  assign do_pop  = i_pop & ~o_empty;
  // full queue still accepts when the head leaves this cycle
  assign do_push = i_push & (~full | do_pop);
  assign o_head  = mem[rd_ptr];

  always_ff @(posedge cclk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_entry;
    end
  end

  always_ff @(posedge cclk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      o_level    <= '0;
      o_drop_cnt <= '0;
    end else begin
      // pointers wrap on their own width
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop) o_level <= o_level + 4'd1;
      if (!do_push && do_pop) o_level <= o_level - 4'd1;
      // saturating drop count
      if (i_push && !do_push && o_drop_cnt != 8'hff) begin
        o_drop_cnt <= o_drop_cnt + 8'd1;
      end
    end
  end

endmodule

/* design/igr_pb_writer.sv */
// round robin drain of the port queues to the packet buffer
// one beat per grant, valid and data hold until ready
// a new grant starts only from idle, so peak rate is one beat per two cycles
`timescale 1ns/1ps
`include "igr_macros.svh"

module igr_pb_writer (
  input  logic                cclk,
  input  logic                rst,
  input  logic [3:0]          i_empty,
  input  igr_pkg::igr_entry_t i_head [0:3],
  output logic [3:0]          o_pop,
  output logic                o_pb_valid,
  input  logic                i_pb_ready,
  output logic [1:0]          o_pb_port,
  output igr_pkg::igr_entry_t o_pb_entry
);

  igr_pkg::pbw_state_e state_q;
  logic [1:0]          last_q;
  logic [1:0]          gnt_port;
  logic                gnt_any;
  logic                load;

  // ----------------------------------------
  // arbiter
  // ----------------------------------------
  // search starts one past the last granted port
  always_comb begin : rr_pick
    logic [1:0] cand;
    gnt_any  = 1'b0;
    gnt_port = last_q;
    for (int i = 1; i <= `IGR_PORTS; i++) begin
      cand = last_q + 2'(i);
      if (!gnt_any && !i_empty[cand]) begin
        gnt_any  = 1'b1;
        gnt_port = cand;
      end
    end
  end

  assign load = (state_q == igr_pkg::PBW_IDLE) && gnt_any;

  // pop the granted queue in the same cycle its head is captured
  always_comb begin
    o_pop = '0;
    if (load) o_pop[gnt_port] = 1'b1;
  end

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_ff @(posedge cclk) begin
    if (rst) begin
      state_q <= igr_pkg::PBW_IDLE;
      // port 0 wins first
      last_q  <= 2'(`IGR_PORTS - 1);
    end else begin
      case (state_q)
        igr_pkg::PBW_IDLE: if (gnt_any) begin
          state_q <= igr_pkg::PBW_HOLD;
          last_q  <= gnt_port;
        end
        igr_pkg::PBW_HOLD: if (i_pb_ready) state_q <= igr_pkg::PBW_IDLE;
        default: state_q <= igr_pkg::PBW_IDLE;
      endcase
    end
  end

  always_ff @(posedge cclk) begin
    if (load) begin
      o_pb_port  <= gnt_port;
      o_pb_entry <= i_head[gnt_port];
    end
  end

  assign o_pb_valid = (state_q == igr_pkg::PBW_HOLD);

endmodule

/* design/igr_pfc_ctrl.sv */
// per port xoff strobes, one tc slot per cycle after the sync pulse
// slot 0 decides from the live level and head, slots 1 to 7 from the latch
`timescale 1ns/1ps
`include "igr_macros.svh"

module igr_pfc_ctrl (
  input  logic            cclk,
  input  logic            rst,
  input  logic            i_tc_sync,
  input  logic [0:3][3:0] i_level,
  input  logic [0:3][2:0] i_head_tc,
  output logic [3:0]      o_pfc_xoff
);

  logic [`IGR_PORTS-1:0] req_now;
  logic [`IGR_PORTS-1:0] req_q;
  logic [0:3][2:0]       tc_q;
  logic [2:0]            slot_q;
  logic [2:0]            cur_slot;

  // the pulse cycle is slot 0
  assign cur_slot = i_tc_sync ? 3'd0 : slot_q;

  always_comb begin
    for (int p = 0; p < `IGR_PORTS; p++) begin
      req_now[p] = (i_level[p] >= 4'(`IGR_XOFF_LVL));
      if (i_tc_sync) begin
        o_pfc_xoff[p] = req_now[p] && (i_head_tc[p] == cur_slot);
      end else begin
        o_pfc_xoff[p] = req_q[p] && (tc_q[p] == cur_slot);
      end
    end
  end

  // request and tc held for the rest of the frame
  always_ff @(posedge cclk) begin
    if (rst) begin
      req_q  <= '0;
      slot_q <= '0;
    end else begin
      slot_q <= cur_slot + 3'd1;
      if (i_tc_sync) req_q <= req_now;
    end
  end

  always_ff @(posedge cclk) begin
    if (i_tc_sync) tc_q <= i_head_tc;
  end

endmodule

/* design/igr_top.sv */
// ingress front end for a four port switch
// EPL beats go to per port queues, drained round robin to the packet buffer
// EPL input has no back-pressure, overflow is dropped and counted per port
`timescale 1ns/1ps
`include "igr_macros.svh"

module igr_top (
  input  logic                              cclk,
  input  logic                              rst,
  input  logic [1:0]                        i_rx_port_num,
  input  logic [`IGR_LANES-1:0]             i_rx_data_v,
  input  logic [`IGR_LANES*`IGR_LANE_W-1:0] i_rx_data,
  input  igr_pkg::epl_md_t                  i_rx_md,
  input  logic [15:0]                       i_rx_ts,
  output logic                              o_pb_valid,
  input  logic                              i_pb_ready,
  output logic [1:0]                        o_pb_port,
  output igr_pkg::igr_entry_t               o_pb_entry,
  output logic [3:0]                        o_pfc_xoff,
  output logic                              o_pfc_tc_sync,
  output logic [0:3][7:0]                   o_drop_cnt
);

  logic [`IGR_PORTS-1:0] push;
  igr_pkg::igr_entry_t   entry;
  logic [`IGR_PORTS-1:0] pop;
  logic [`IGR_PORTS-1:0] empty;
  igr_pkg::igr_entry_t   head [0:3];
  logic [0:3][3:0]       level;
  logic [0:3][2:0]       head_tc;

  // ----------------------------------------
  // receive and steer
  // ----------------------------------------
  igr_dpc u_dpc (
    .cclk          (cclk),
    .rst           (rst),
    .i_rx_port_num (i_rx_port_num),
    .i_rx_data_v   (i_rx_data_v),
    .i_rx_data     (i_rx_data),
    .i_rx_md       (i_rx_md),
    .i_rx_ts       (i_rx_ts),
    .o_push        (push),
    .o_entry       (entry),
    .o_pfc_tc_sync (o_pfc_tc_sync)
  );

  // one queue per logical port
  for (genvar g = 0; g < `IGR_PORTS; g++) begin : g_port
    igr_port_fifo u_fifo (
      .cclk       (cclk),
      .rst        (rst),
      .i_push     (push[g]),
      .i_entry    (entry),
      .i_pop      (pop[g]),
      .o_head     (head[g]),
      .o_empty    (empty[g]),
      .o_level    (level[g]),
      .o_drop_cnt (o_drop_cnt[g])
    );
    assign head_tc[g] = head[g].tc;
  end

  // ----------------------------------------
  // drain and pause
  // ----------------------------------------
  igr_pb_writer u_writer (
    .cclk       (cclk),
    .rst        (rst),
    .i_empty    (empty),
    .i_head     (head),
    .o_pop      (pop),
    .o_pb_valid (o_pb_valid),
    .i_pb_ready (i_pb_ready),
    .o_pb_port  (o_pb_port),
    .o_pb_entry (o_pb_entry)
  );

  igr_pfc_ctrl u_pfc (
    .cclk       (cclk),
    .rst        (rst),
    .i_tc_sync  (o_pfc_tc_sync),
    .i_level    (level),
    .i_head_tc  (head_tc),
    .o_pfc_xoff (o_pfc_xoff)
  );

endmodule

/* bench/igr_tb.sv */
// EPL beats from a table are checked against per-port reference queues
// drop rows assume the writer starts idle and ready stays low while the port fills
// data, metadata and timestamps come from a 16-bit LFSR with seed 1
`timescale 1ns/1ps
`include "igr_macros.svh"

module igr_tb;

  localparam int K_PASS = 0;
  localparam int K_DROP = 1;
  localparam int K_NONE = 2;

  // one EPL beat plus what the packet buffer side should see
  typedef struct {
    int               test;
    logic [1:0]       port;
    logic [3:0]       v;
    logic [63:0]      data;
    igr_pkg::epl_md_t md;
    logic [15:0]      ts;
    logic             rdy;
    int               kind;
    // -1 no xoff check, 0..7 slot for this port, 8 all strobes low
    int               xtc;
  } row_t;

  logic                cclk;
  logic                rst;
  logic [1:0]          i_rx_port_num;
  logic [3:0]          i_rx_data_v;
  logic [63:0]         i_rx_data;
  igr_pkg::epl_md_t    i_rx_md;
  logic [15:0]         i_rx_ts;
  logic                i_pb_ready;
  logic                o_pb_valid;
  logic [1:0]          o_pb_port;
  igr_pkg::igr_entry_t o_pb_entry;
  logic [3:0]          o_pfc_xoff;
  logic                o_pfc_tc_sync;
  logic [0:3][7:0]     o_drop_cnt;

  row_t                rows [$];
  igr_pkg::igr_entry_t exp_q [4][$];
  int                  exp_drop [4] = '{0, 0, 0, 0};
  string               names [3] = '{"stream", "round robin", "back-pressure and pause"};
  logic [15:0]         lfsr = 16'h0001;
  logic                table_ready = 1'b0;
  logic                hold_chk = 1'b0;
  igr_pkg::igr_entry_t held_e;
  int                  errors = 0;
  int                  checks = 0;
  int                  err_mark = 0;
  int                  cur_test = 0;
  int                  cur_xtc = -1;
  int                  cur_xport = 0;
  int                  test_xfers = 0;
  int                  last_gnt = 3;
  int                  since = 0;
  int                  slot = 0;

  // port names match the testbench signals
  igr_top u_dut (.*);

  initial begin
    cclk = 1'b0;
    forever #4 cclk = ~cclk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  // fibonacci LFSR with taps 16 14 13 11 and one step per bit
  function automatic logic [63:0] take_bits(int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[62:0], fb};
    end
    return r;
  endfunction

  task automatic expect_eq(string sig, logic [95:0] exp, logic [95:0] got);
    checks++;
    assert (exp === got) else begin
      $display("FAIL %0t %s expected %0h got %0h", $time, sig, exp, got);
      errors++;
    end
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < 4; p++) begin
      n += exp_q[p].size();
    end
    return n;
  endfunction

  // first port after the last grant that still owes a beat
  function automatic int rr_next();
    int q;
    for (int i = 1; i <= 4; i++) begin
      q = (last_gnt + i) % 4;
      if (exp_q[q].size() != 0) return q;
    end
    return -1;
  endfunction

  task automatic add_row(int test, int port, logic [3:0] v, logic rdy, int kind, int xtc,
                         logic [2:0] tc);
    row_t       r;
    logic [2:0] flags;
    flags  = 3'(take_bits(3));
    r.test = test;
    r.port = 2'(port);
    r.v    = v;
    r.data = take_bits(64);
    r.md   = {flags, tc};
    r.ts   = 16'(take_bits(16));
    r.rdy  = rdy;
    r.kind = kind;
    r.xtc  = xtc;
    rows.push_back(r);
  endtask

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------
  task automatic build_table();
    logic [3:0] v;
    // mixed ports where some beats carry no valid lanes
    for (int i = 0; i < 16; i++) begin
      v = 4'(take_bits(4));
      add_row(1, i % 4, v, 1'b1, (v != 0) ? K_PASS : K_NONE, -1, 3'(take_bits(3)));
    end
    // load all four queues behind a stalled writer, then release
    for (int i = 0; i < 23; i++) begin
      v = (i < 12) ? (4'(take_bits(4)) | 4'h1) : 4'h0;
      add_row(2, i % 4, v, i >= 15, (i < 12) ? K_PASS : K_NONE, -1, 3'(take_bits(3)));
    end
    // writer holds the first beat, so eight more fit before drops start
    for (int i = 0; i < 12; i++) begin
      add_row(3, 2, 4'(take_bits(4)) | 4'h1, 1'b0,
              (i <= `IGR_FIFO_DEPTH) ? K_PASS : K_DROP, -1, 3'd5);
    end
    // stalled at level 8 with head tc 5
    for (int i = 0; i < 26; i++) begin
      add_row(3, 2, 4'h0, 1'b0, K_NONE, (i < 10) ? -1 : 5, 3'd5);
    end
    // strobes gone one frame after the drain takes the level below xoff
    for (int i = 0; i < 24; i++) begin
      add_row(3, 2, 4'h0, 1'b1, K_NONE, (i < 14) ? -1 : 8, 3'd5);
    end
  endtask

  task automatic apply_row(row_t r);
    igr_pkg::igr_entry_t e;
    if (r.test != cur_test) begin
      cur_test   = r.test;
      test_xfers = 0;
    end
    i_rx_port_num = r.port;
    i_rx_data_v   = r.v;
    i_rx_data     = r.data;
    i_rx_md       = r.md;
    i_rx_ts       = r.ts;
    i_pb_ready    = r.rdy;
    cur_xtc       = r.xtc;
    cur_xport     = r.port;
    // lane count is the number of set valid bits
    e.data  = r.data;
    e.lanes = 3'($countones(r.v));
    e.sop   = r.md.sop;
    e.eop   = r.md.eop;
    e.error = r.md.error;
    e.tc    = r.md.tc;
    e.ts    = r.ts;
    if (r.kind == K_PASS) begin
      exp_q[r.port].push_back(e);
    end else if (r.kind == K_DROP) begin
      exp_drop[r.port]++;
    end
  endtask

  task automatic finish_test(int t);
    @(posedge cclk);
    #1;
    i_rx_data_v = '0;
    i_pb_ready  = 1'b1;
    cur_xtc     = -1;
    while (pending() != 0) @(posedge cclk);
    repeat (4) @(negedge cclk);
    for (int p = 0; p < 4; p++) begin
      expect_eq($sformatf("o_drop_cnt[%0d]", p), exp_drop[p], o_drop_cnt[p]);
    end
    $display("test %0d %s: %0d errors", t, names[t-1], errors - err_mark);
    err_mark = errors;
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : stimulus
    rst           = 1'b1;
    i_rx_port_num = '0;
    i_rx_data_v   = '0;
    i_rx_data     = '0;
    i_rx_md       = '0;
    i_rx_ts       = '0;
    i_pb_ready    = 1'b1;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge cclk);
    #1;
    rst = 1'b0;
    for (int r = 0; r < rows.size(); r++) begin
      if (r > 0 && rows[r].test != rows[r-1].test) begin
        finish_test(rows[r-1].test);
      end
      @(posedge cclk);
      #1;
      apply_row(rows[r]);
    end
    finish_test(rows[rows.size()-1].test);
    // quiet tail where any stray beat shows up as unexpected
    repeat (10) @(negedge cclk);
    $display("tests 3, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // ----------------------------------------
  // output monitor sampled mid cycle
  // ----------------------------------------
  always @(negedge cclk) begin : monitor
    int p;
    if (rst) begin
      since = 0;
    end else begin
      since++;
      // first pulse in the third cycle after reset release
      expect_eq("o_pfc_tc_sync", (since >= 3) && ((since - 3) % `IGR_TC_SLOTS == 0),
                o_pfc_tc_sync);
      // slot 0 is the pulse cycle of each frame
      slot = (since >= 3) ? (since - 3) % `IGR_TC_SLOTS : -1;
      if (cur_xtc >= 0) begin
        expect_eq("o_pfc_xoff", (slot == cur_xtc) ? 4'(1 << cur_xport) : 4'h0, o_pfc_xoff);
      end
      // a stalled beat must not move
      if (hold_chk) begin
        expect_eq("o_pb_valid", 1'b1, o_pb_valid);
        expect_eq("o_pb_entry", held_e, o_pb_entry);
      end
      hold_chk = o_pb_valid && !i_pb_ready;
      held_e   = o_pb_entry;
      if (o_pb_valid && i_pb_ready) begin
        p = o_pb_port;
        assert (exp_q[p].size() != 0) else begin
          $display("unexpected beat on port %0d at %0t", p, $time);
          errors++;
        end
        if (exp_q[p].size() != 0) begin
          // first grant of the round robin test happens before the other queues fill
          if (cur_test == 2 && test_xfers > 0) begin
            expect_eq("o_pb_port", rr_next(), p);
          end
          expect_eq("o_pb_entry", exp_q[p][0], o_pb_entry);
          void'(exp_q[p].pop_front());
        end
        last_gnt = p;
        test_xfers++;
      end
    end
  end

  // limit is 40 cycles per table row
  initial begin : watchdog
    wait (table_ready);
    repeat (rows.size() * 40) @(posedge cclk);
    $display("watchdog expired, the run did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
design/igr_pkg.sv
design/igr_dpc.sv
design/igr_port_fifo.sv
design/igr_pb_writer.sv
design/igr_pfc_ctrl.sv
design/igr_top.sv
bench/igr_tb.sv

/* Bender.yml */
package:
  name: igr_front_end

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/igr_pkg.sv
      - design/igr_dpc.sv
      - design/igr_port_fifo.sv
      - design/igr_pb_writer.sv
      - design/igr_pfc_ctrl.sv
      - design/igr_top.sv
      - target: test
        files:
          - bench/igr_tb.sv
